// ==== build.f ====
verilog/mem_pkg.sv
verilog/mem_arbiter.sv
verilog/mtimer.sv
verilog/axi_rw_master.sv
verilog/mem_subsys.sv
testbench/mem_subsys_chk.sv
testbench/mem_subsys_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_subsys_tb -f build.f -o mem_subsys_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/mem_subsys_sim > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error status"
  exit 1
fi
cat "$LOG"

if grep -qx "TB PASSED" "$LOG"; then
  echo "result: pass"
  exit 0
fi

echo "result: fail"
exit 1

// ==== testbench/mem_subsys_tb.sv ====
// memory subsystem testbench: clock, reset, AXI slave memory model
// with random stalls, directed tests, compare tasks and watchdog
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb
  import mem_pkg::*;
();

  localparam int                CLK_PERIOD = 4;
  localparam logic [ADDR_W-1:0] TIMER_BASE = 64'h0200_0000;
  localparam logic [ADDR_W-1:0] EXT_BASE   = 64'h8000_0000;
  localparam int                ACC_LIMIT  = 64;
  // accesses over all tests, worst cycles per stalled access, plain waits
  localparam int N_ACCESS    = 32;
  localparam int WORST_CYC   = 24;
  localparam int WAIT_CYC    = 200;
  localparam int WATCHDOG_NS = 2 * CLK_PERIOD * (N_ACCESS * WORST_CYC + WAIT_CYC);

  logic       clk;
  logic       rst_n;
  fetch_req_t i_fetch;
  fetch_rsp_t o_fetch;
  lsu_req_t   i_lsu;
  lsu_rsp_t   o_lsu;
  axi_req_t   o_axi;
  axi_rsp_t   i_axi;
  logic       o_timer_int;

  // sparse slave memory, one entry per doubleword
  logic [XLEN-1:0]   mem [logic [ADDR_W-4:0]];
  int                errors;
  int                checks;
  int                tests;
  logic              aw_got;
  logic              w_got;
  logic              ar_got;
  logic              b_hs;
  logic              r_hs;
  logic [ADDR_W-1:0] aw_addr;
  logic [ADDR_W-1:0] ar_addr;
  size_t             aw_size;
  size_t             ar_size;
  logic [XLEN-1:0]   w_data;
  logic [STRB_W-1:0] w_strb;
  int                aw_wait;
  int                w_wait;
  int                b_wait;
  int                ar_wait;
  int                r_wait;

  mem_subsys #(
    .TIMER_BASE (TIMER_BASE),
    .TICK_DIV   (1)
  ) mem_subsys_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_fetch     (i_fetch),
    .o_fetch     (o_fetch),
    .i_lsu       (i_lsu),
    .o_lsu       (o_lsu),
    .o_axi       (o_axi),
    .i_axi       (i_axi),
    .o_timer_int (o_timer_int)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic int stall_cycles();
    return $urandom % 4;
  endfunction

  // never written words still differ per address
  function automatic logic [XLEN-1:0] read_mem(logic [ADDR_W-1:0] addr);
    if (mem.exists(addr[ADDR_W-1:3])) begin
      return mem[addr[ADDR_W-1:3]];
    end
    return {addr[31:0], addr[63:32]} ^ 64'h5a5a_c3c3_0f0f_9696;
  endfunction

  task automatic write_mem(logic [ADDR_W-1:0] addr, logic [XLEN-1:0] data,
                           logic [STRB_W-1:0] strb);
    logic [XLEN-1:0] word;
    word = read_mem(addr);
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) begin
        word[8*i +: 8] = data[8*i +: 8];
      end
    end
    mem[addr[ADDR_W-1:3]] = word;
  endtask

  // AXI slave, every decision taken on the falling edge
  initial begin
    i_axi   = '0;
    aw_got  = 1'b0;
    w_got   = 1'b0;
    ar_got  = 1'b0;
    b_hs    = 1'b0;
    r_hs    = 1'b0;
    aw_size = '0;
    ar_size = '0;
    aw_wait = 0;
    w_wait  = 0;
    b_wait  = 0;
    ar_wait = 0;
    r_wait  = 0;
    forever begin
      @(negedge clk);
      // responses first, so address flags set below count from the next edge
      if (b_hs) begin
        i_axi.b_valid = 1'b0;
        b_hs = 1'b0;
      end else if (i_axi.b_valid) begin
        b_hs = o_axi.b_ready;
      end else if (aw_got && w_got) begin
        if (b_wait != 0) begin
          b_wait--;
        end else begin
          write_mem(aw_addr, w_data, w_strb);
          aw_got = 1'b0;
          w_got = 1'b0;
          i_axi.b_valid = 1'b1;
          b_hs = o_axi.b_ready;
          b_wait = stall_cycles();
        end
      end
      if (r_hs) begin
        i_axi.r_valid = 1'b0;
        r_hs = 1'b0;
      end else if (i_axi.r_valid) begin
        r_hs = o_axi.r_ready;
      end else if (ar_got) begin
        if (r_wait != 0) begin
          r_wait--;
        end else begin
          i_axi.r_data = read_mem(ar_addr);
          i_axi.r_valid = 1'b1;
          ar_got = 1'b0;
          r_hs = o_axi.r_ready;
          r_wait = stall_cycles();
        end
      end
      if (i_axi.aw_ready) begin
        i_axi.aw_ready = 1'b0;
      end else if (o_axi.aw_valid && !aw_got) begin
        if (aw_wait != 0) begin
          aw_wait--;
        end else begin
          i_axi.aw_ready = 1'b1;
          aw_addr = o_axi.aw_addr;
          aw_size = o_axi.aw_size;
          aw_got = 1'b1;
          aw_wait = stall_cycles();
        end
      end
      if (i_axi.w_ready) begin
        i_axi.w_ready = 1'b0;
      end else if (o_axi.w_valid && !w_got) begin
        if (w_wait != 0) begin
          w_wait--;
        end else begin
          i_axi.w_ready = 1'b1;
          w_data = o_axi.w_data;
          w_strb = o_axi.w_strb;
          w_got = 1'b1;
          w_wait = stall_cycles();
        end
      end
      if (i_axi.ar_ready) begin
        i_axi.ar_ready = 1'b0;
      end else if (o_axi.ar_valid && !ar_got) begin
        if (ar_wait != 0) begin
          ar_wait--;
        end else begin
          i_axi.ar_ready = 1'b1;
          ar_addr = o_axi.ar_addr;
          ar_size = o_axi.ar_size;
          ar_got = 1'b1;
          ar_wait = stall_cycles();
        end
      end
    end
  end

  task automatic check_word(string name, bus_word_u got, bus_word_u exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%h expected 0x%h", name, got.dword, exp.dword);
    end
  endtask

  task automatic check_word_range(string name, bus_word_u got, bus_word_u lo,
                                  bus_word_u hi);
    checks++;
    if (got.dword < lo.dword || got.dword > hi.dword) begin
      errors++;
      $display("Fail %s: got 0x%h expected 0x%h to 0x%h", name, got.dword,
               lo.dword, hi.dword);
    end
  endtask

  task automatic check_fetch(string name, fetch_rsp_t got, fetch_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_size(string name, size_t got, size_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // called on a falling edge, returns one idle cycle after ready
  task automatic lsu_access(input logic wen, input logic [ADDR_W-1:0] addr,
                            input logic [XLEN-1:0] wdata, input size_t size,
                            output bus_word_u rdata, output int lat);
    i_lsu.valid = 1'b1;
    i_lsu.wen   = wen;
    i_lsu.addr  = addr;
    i_lsu.wdata = wdata;
    i_lsu.size  = size;
    lat = 0;
    rdata = '0;
    do begin
      @(negedge clk);
      lat++;
    end while (!o_lsu.ready && lat < ACC_LIMIT);
    if (o_lsu.ready) begin
      rdata = o_lsu.rdata;
    end else begin
      errors++;
      $display("load/store at 0x%h got no ready within %0d cycles", addr, ACC_LIMIT);
    end
    i_lsu.valid = 1'b0;
    @(negedge clk);
  endtask

  task automatic lsu_write(logic [ADDR_W-1:0] addr, logic [XLEN-1:0] data, size_t size);
    bus_word_u ignored_rdata;
    int        lat;
    lsu_access(1'b1, addr, data, size, ignored_rdata, lat);
  endtask

  task automatic lsu_read(input logic [ADDR_W-1:0] addr, output bus_word_u rdata);
    int lat;
    lsu_access(1'b0, addr, '0, 3'd3, rdata, lat);
  endtask

  task automatic fetch_access(input logic [ADDR_W-1:0] addr, output fetch_rsp_t rsp,
                              output int lat);
    i_fetch.valid = 1'b1;
    i_fetch.addr  = addr;
    lat = 0;
    rsp = '0;
    do begin
      @(negedge clk);
      lat++;
    end while (!o_fetch.ready && lat < ACC_LIMIT);
    if (o_fetch.ready) begin
      rsp = o_fetch;
    end else begin
      errors++;
      $display("fetch at 0x%h got no ready within %0d cycles", addr, ACC_LIMIT);
    end
    i_fetch.valid = 1'b0;
    @(negedge clk);
  endtask

  task automatic end_test(string name, int err0);
    tests++;
    if (errors == err0) begin
      $display("test %-14s ok", name);
    end else begin
      $display("test %-14s %0d errors", name, errors - err0);
    end
  endtask

  task automatic test_ext_rw();
    logic [XLEN-1:0] data [6];
    bus_word_u       rd;
    int              err0;
    err0 = errors;
    for (int i = 0; i < 6; i++) begin
      data[i] = {$urandom, $urandom};
      lsu_write(EXT_BASE + 64'h108 * i, data[i], 3'd3);
    end
    for (int i = 0; i < 6; i++) begin
      lsu_read(EXT_BASE + 64'h108 * i, rd);
      check_word($sformatf("o_lsu.rdata[%0d]", i), rd, data[i]);
    end
    end_test("ext_rw", err0);
  endtask

  task automatic test_byte_write();
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   exp;
    bus_word_u         rd;
    int                err0;
    err0 = errors;
    addr = EXT_BASE + 64'h2000;
    lsu_write(addr, 64'h0123_4567_89ab_cdef, 3'd3);
    // byte lane 5, data already sits in its lane
    lsu_write(addr + 64'd5, {8{8'h5a}}, 3'd0);
    check_size("o_axi.aw_size", aw_size, 3'd0);
    exp = 64'h0123_4567_89ab_cdef;
    exp[47:40] = 8'h5a;
    lsu_read(addr, rd);
    check_size("o_axi.ar_size", ar_size, 3'd3);
    check_word("o_lsu.rdata", rd, exp);
    end_test("byte_write", err0);
  endtask

  task automatic test_fetch_halves();
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   word;
    fetch_rsp_t        rsp;
    int                lat;
    int                err0;
    err0 = errors;
    addr = EXT_BASE + 64'h3000;
    word = 64'h0051_0513_00a0_0093;
    lsu_write(addr, word, 3'd3);
    fetch_access(addr, rsp, lat);
    check_size("o_axi.ar_size", ar_size, 3'd2);
    check_fetch("o_fetch", rsp, fetch_rsp_t'({1'b1, word[31:0]}));
    fetch_access(addr + 64'd4, rsp, lat);
    check_fetch("o_fetch", rsp, fetch_rsp_t'({1'b1, word[63:32]}));
    end_test("fetch_halves", err0);
  endtask

  task automatic test_priority();
    logic [XLEN-1:0] d_lsu;
    logic [XLEN-1:0] d_fetch;
    bus_word_u       rd;
    fetch_rsp_t      rsp;
    int              lat_lsu;
    int              lat_fetch;
    int              err0;
    err0 = errors;
    d_lsu = {$urandom, $urandom};
    d_fetch = {$urandom, $urandom};
    lsu_write(EXT_BASE + 64'h4000, d_lsu, 3'd3);
    lsu_write(EXT_BASE + 64'h4100, d_fetch, 3'd3);
    fork
      lsu_access(1'b0, EXT_BASE + 64'h4000, '0, 3'd3, rd, lat_lsu);
      fetch_access(EXT_BASE + 64'h4104, rsp, lat_fetch);
    join
    check_bit("o_lsu.ready before o_fetch.ready", lat_lsu < lat_fetch, 1'b1);
    check_word("o_lsu.rdata", rd, d_lsu);
    check_fetch("o_fetch", rsp, fetch_rsp_t'({1'b1, d_fetch[63:32]}));
    end_test("priority", err0);
  endtask

  task automatic test_timer_regs();
    logic [XLEN-1:0] cmp_val;
    logic [XLEN-1:0] time_val;
    bus_word_u       rd;
    int              lat_w;
    int              lat_r;
    int              err0;
    err0 = errors;
    cmp_val = 64'h0000_1234_5678_9abc;
    time_val = 64'h0000_0000_0000_1000;
    lsu_access(1'b1, TIMER_BASE + MTIMECMP_OFF, cmp_val, 3'd3, rd, lat_w);
    check_bit("timer write ready after 2 cycles", lat_w == 2, 1'b1);
    lsu_read(TIMER_BASE + MTIMECMP_OFF, rd);
    check_word("mtimecmp", rd, cmp_val);
    lsu_access(1'b1, TIMER_BASE + MTIME_OFF, time_val, 3'd3, rd, lat_w);
    lsu_access(1'b0, TIMER_BASE + MTIME_OFF, '0, 3'd3, rd, lat_r);
    check_bit("timer read ready after 2 cycles", lat_r == 2, 1'b1);
    check_word_range("mtime", rd, time_val, time_val + (lat_w + lat_r + 1));
    end_test("timer_regs", err0);
  endtask

  task automatic test_timer_int();
    int n;
    int err0;
    err0 = errors;
    lsu_write(TIMER_BASE + MTIME_OFF, 64'd0, 3'd3);
    lsu_write(TIMER_BASE + MTIMECMP_OFF, 64'd40, 3'd3);
    check_bit("o_timer_int", o_timer_int, 1'b0);
    n = 0;
    while (!o_timer_int && n < 48) begin
      @(negedge clk);
      n++;
    end
    check_bit("o_timer_int", o_timer_int, 1'b1);
    lsu_write(TIMER_BASE + MTIMECMP_OFF, '1, 3'd3);
    check_bit("o_timer_int", o_timer_int, 1'b0);
    end_test("timer_int", err0);
  endtask

  initial begin
    void'($urandom(32'h3032));
    errors = 0;
    checks = 0;
    tests = 0;
    rst_n = 1'b0;
    i_fetch = '0;
    i_lsu = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_ext_rw();
    test_byte_write();
    test_fetch_halves();
    test_priority();
    test_timer_regs();
    test_timer_int();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, a test hung", WATCHDOG_NS);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/mem_subsys_chk.sv ====
// bound assertions: AXI address valid hold, aw/ar exclusivity,
// requester ready exclusivity, timer interrupt low out of reset
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_chk
  import mem_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input fetch_rsp_t i_fetch_rsp,
  input lsu_rsp_t   i_lsu_rsp,
  input axi_req_t   i_axi_req,
  input axi_rsp_t   i_axi_rsp,
  input logic       i_timer_int
);

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_axi_req.aw_valid && !i_axi_rsp.aw_ready |=> i_axi_req.aw_valid)
    else $error("aw_valid dropped before aw_ready");

  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_axi_req.ar_valid && !i_axi_rsp.ar_ready |=> i_axi_req.ar_valid)
    else $error("ar_valid dropped before ar_ready");

  aw_ar_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(i_axi_req.aw_valid && i_axi_req.ar_valid))
    else $error("aw_valid and ar_valid high together");

  ready_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(i_fetch_rsp.ready && i_lsu_rsp.ready))
    else $error("fetch and load/store ready in the same cycle");

  // first cycle out of reset
  int_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !i_timer_int)
    else $error("timer interrupt high right after reset");

endmodule

bind mem_subsys mem_subsys_chk mem_subsys_chk_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .i_fetch_rsp (o_fetch),
  .i_lsu_rsp   (o_lsu),
  .i_axi_req   (o_axi),
  .i_axi_rsp   (i_axi),
  .i_timer_int (o_timer_int)
);

`default_nettype wire

// ==== verilog/mem_subsys.sv ====
// memory subsystem top: arbiter, machine timer, AXI master
`timescale 1ns/1ps
`default_nettype none

module mem_subsys
  import mem_pkg::*;
#(
  parameter logic [ADDR_W-1:0] TIMER_BASE = 64'h0200_0000,
  parameter int unsigned       TICK_DIV   = 1
) (
  input  logic       clk,
  input  logic       rst_n,
  input  fetch_req_t i_fetch,
  output fetch_rsp_t o_fetch,
  input  lsu_req_t   i_lsu,
  output lsu_rsp_t   o_lsu,
  output axi_req_t   o_axi,
  input  axi_rsp_t   i_axi,
  output logic       o_timer_int
);

  bus_req_t timer_req;
  bus_rsp_t timer_rsp;
  bus_req_t ext_req;
  bus_rsp_t ext_rsp;

  mem_arbiter #(
    .TIMER_BASE (TIMER_BASE)
  ) mem_arbiter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_fetch     (i_fetch),
    .o_fetch     (o_fetch),
    .i_lsu       (i_lsu),
    .o_lsu       (o_lsu),
    .o_timer_req (timer_req),
    .i_timer_rsp (timer_rsp),
    .o_ext_req   (ext_req),
    .i_ext_rsp   (ext_rsp)
  );

  mtimer #(
    .TICK_DIV (TICK_DIV)
  ) mtimer_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_req       (timer_req),
    .o_rsp       (timer_rsp),
    .o_timer_int (o_timer_int)
  );

  axi_rw_master axi_rw_master_i (
    .clk   (clk),
    .rst_n (rst_n),
    .i_req (ext_req),
    .o_rsp (ext_rsp),
    .o_axi (o_axi),
    .i_axi (i_axi)
  );

endmodule

`default_nettype wire

// ==== verilog/axi_rw_master.sv ====
// single-beat AXI master, one read or write at a time
// write strobes from size and low address bits
`timescale 1ns/1ps
`default_nettype none

module axi_rw_master
  import mem_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  bus_req_t i_req,
  output bus_rsp_t o_rsp,
  output axi_req_t o_axi,
  input  axi_rsp_t i_axi
);

  axi_state_e        state_q;
  logic              aw_done_q;
  logic              w_done_q;
  logic              ready_q;
  logic [ADDR_W-1:0] addr_q;
  logic [XLEN-1:0]   wdata_q;
  size_t             size_q;
  bus_word_u         rdata_q;
  logic              start;
  logic              aw_hs;
  logic              w_hs;
  logic              b_hs;
  logic              ar_hs;
  logic              r_hs;

  // valid is still high in the ready cycle, do not restart on it
  assign start = (state_q == ST_IDLE) & i_req.valid & ~ready_q;

  always_comb begin
    o_axi          = '0;
    o_axi.aw_valid = (state_q == ST_WADDR) & ~aw_done_q;
    o_axi.aw_addr  = addr_q;
    o_axi.aw_size  = size_q;
    o_axi.w_valid  = (state_q == ST_WADDR) & ~w_done_q;
    o_axi.w_data   = wdata_q;
    o_axi.w_strb   = byte_strb(size_q, addr_q[2:0]);
    o_axi.b_ready  = state_q == ST_WRESP;
    o_axi.ar_valid = state_q == ST_RADDR;
    o_axi.ar_addr  = addr_q;
    o_axi.ar_size  = size_q;
    o_axi.r_ready  = state_q == ST_RDATA;
  end

  assign aw_hs = o_axi.aw_valid & i_axi.aw_ready;
  assign w_hs  = o_axi.w_valid & i_axi.w_ready;
  assign b_hs  = o_axi.b_ready & i_axi.b_valid;
  assign ar_hs = o_axi.ar_valid & i_axi.ar_ready;
  assign r_hs  = o_axi.r_ready & i_axi.r_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= ST_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      ready_q   <= 1'b0;
    end else begin
      ready_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start) begin
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            state_q   <= i_req.wen ? ST_WADDR : ST_RADDR;
          end
        end
        ST_WADDR: begin
          // aw and w may be accepted in either order
          if (aw_hs) begin
            aw_done_q <= 1'b1;
          end
          if (w_hs) begin
            w_done_q <= 1'b1;
          end
          if ((aw_done_q | aw_hs) & (w_done_q | w_hs)) begin
            state_q <= ST_WRESP;
          end
        end
        ST_WRESP: begin
          if (b_hs) begin
            state_q <= ST_IDLE;
            ready_q <= 1'b1;
          end
        end
        ST_RADDR: begin
          if (ar_hs) begin
            state_q <= ST_RDATA;
          end
        end
        ST_RDATA: begin
          if (r_hs) begin
            state_q <= ST_IDLE;
            ready_q <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      addr_q  <= i_req.addr;
      wdata_q <= i_req.wdata;
      size_q  <= i_req.size;
    end
    if (r_hs) begin
      rdata_q.dword <= i_axi.r_data;
    end
  end

  always_comb begin
    o_rsp.ready = ready_q;
    o_rsp.rdata = rdata_q;
  end

endmodule

`default_nettype wire

// ==== verilog/mtimer.sv ====
// machine timer: prescaled mtime, mtimecmp, register access
// and the registered timer interrupt level
`timescale 1ns/1ps
`default_nettype none

module mtimer
  import mem_pkg::*;
#(
  parameter int unsigned TICK_DIV = 1
) (
  input  logic     clk,
  input  logic     rst_n,
  input  bus_req_t i_req,
  output bus_rsp_t o_rsp,
  output logic     o_timer_int
);

  logic [XLEN-1:0] mtime_q;
  logic [XLEN-1:0] mtimecmp_q;
  logic [31:0]     presc_q;
  logic            busy_q;
  logic            ready_q;
  logic            int_q;
  bus_word_u       rdata_q;
  logic            accept;
  logic            tick;
  logic [15:0]     off;
  logic [STRB_W-1:0] strb;
  logic [XLEN-1:0] wmask;

  assign off    = i_req.addr[15:0];
  // a held valid is answered once
  assign accept = i_req.valid & ~busy_q;
  assign tick   = presc_q == TICK_DIV - 1;
  assign strb   = byte_strb(i_req.size, i_req.addr[2:0]);

  always_comb begin
    wmask = '0;
    for (int i = 0; i < STRB_W; i++) begin
      wmask[8*i +: 8] = {8{strb[i]}};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      presc_q    <= '0;
      busy_q     <= 1'b0;
      ready_q    <= 1'b0;
      int_q      <= 1'b0;
    end else begin
      busy_q  <= i_req.valid;
      ready_q <= accept;
      int_q   <= mtime_q >= mtimecmp_q;
      presc_q <= tick ? '0 : presc_q + 32'd1;
      if (tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (accept && i_req.wen && off == MTIME_OFF) begin
        mtime_q <= (mtime_q & ~wmask) | (i_req.wdata & wmask);
        presc_q <= '0;
      end
      if (accept && i_req.wen && off == MTIMECMP_OFF) begin
        mtimecmp_q <= (mtimecmp_q & ~wmask) | (i_req.wdata & wmask);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      case (off)
        MTIME_OFF:    rdata_q.dword <= mtime_q;
        MTIMECMP_OFF: rdata_q.dword <= mtimecmp_q;
        default:      rdata_q.dword <= '0;
      endcase
    end
  end

  always_comb begin
    o_rsp.ready = ready_q;
    o_rsp.rdata = rdata_q;
  end

  assign o_timer_int = int_q;

endmodule

`default_nettype wire

// ==== verilog/mem_arbiter.sv ====
// fetch vs load/store arbiter, load/store first
// timer/bus address decode and response routing
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
  import mem_pkg::*;
#(
  parameter logic [ADDR_W-1:0] TIMER_BASE = 64'h0200_0000
) (
  input  logic       clk,
  input  logic       rst_n,
  input  fetch_req_t i_fetch,
  output fetch_rsp_t o_fetch,
  input  lsu_req_t   i_lsu,
  output lsu_rsp_t   o_lsu,
  output bus_req_t   o_timer_req,
  input  bus_rsp_t   i_timer_rsp,
  output bus_req_t   o_ext_req,
  input  bus_rsp_t   i_ext_rsp
);

  typedef enum logic [1:0] {
    GNT_NONE,
    GNT_FETCH,
    GNT_LSU
  } grant_e;

  grant_e    grant_q;
  bus_req_t  req;
  logic      to_timer;
  logic      rsp_ready;
  bus_word_u rsp_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      grant_q <= GNT_NONE;
    end else if (grant_q == GNT_NONE) begin
      if (i_lsu.valid) begin
        grant_q <= GNT_LSU;
      end else if (i_fetch.valid) begin
        grant_q <= GNT_FETCH;
      end
    end else if (rsp_ready) begin
      grant_q <= GNT_NONE;
    end
  end

  always_comb begin
    req = '0;
    case (grant_q)
      GNT_LSU: begin
        req.valid = 1'b1;
        req.wen   = i_lsu.wen;
        req.addr  = i_lsu.addr;
        req.wdata = i_lsu.wdata;
        req.size  = i_lsu.size;
      end
      GNT_FETCH: begin
        req.valid = 1'b1;
        req.addr  = i_fetch.addr;
        // instructions are always word sized
        req.size  = 3'd2;
      end
      default: ;
    endcase
  end

  // 64 KiB timer window
  assign to_timer = req.addr[ADDR_W-1:16] == TIMER_BASE[ADDR_W-1:16];

  always_comb begin
    o_timer_req       = req;
    o_timer_req.valid = req.valid & to_timer;
    o_ext_req         = req;
    o_ext_req.valid   = req.valid & ~to_timer;
  end

  assign rsp_ready = req.valid & (to_timer ? i_timer_rsp.ready : i_ext_rsp.ready);
  assign rsp_data  = to_timer ? i_timer_rsp.rdata : i_ext_rsp.rdata;

  always_comb begin
    o_lsu.ready   = (grant_q == GNT_LSU) & rsp_ready;
    o_lsu.rdata   = rsp_data.dword;
    o_fetch.ready = (grant_q == GNT_FETCH) & rsp_ready;
    // addr bit 2 picks the instruction half
    o_fetch.instr = rsp_data.instr[i_fetch.addr[2]];
  end

endmodule

`default_nettype wire

// ==== verilog/mem_pkg.sv ====
// widths, timer register offsets and strobe helper
// request/response structs, bus word union, AXI master states
`default_nettype none

package mem_pkg;

  localparam int ADDR_W = 64;
  localparam int XLEN   = 64;
  localparam int STRB_W = XLEN / 8;

  // log2 of byte count, same coding as AXI size
  typedef logic [2:0] size_t;

  localparam logic [15:0] MTIMECMP_OFF = 16'h4000;
  localparam logic [15:0] MTIME_OFF    = 16'hBFF8;

  // doubleword for load/store, two instruction words for fetch
  typedef union packed {
    logic [XLEN-1:0]  dword;
    logic [1:0][31:0] instr;
  } bus_word_u;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] instr;
  } fetch_rsp_t;

  typedef struct packed {
    logic              valid;
    logic              wen;
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   wdata;
    size_t             size;
  } lsu_req_t;

  typedef struct packed {
    logic            ready;
    logic [XLEN-1:0] rdata;
  } lsu_rsp_t;

  typedef struct packed {
    logic              valid;
    logic              wen;
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   wdata;
    size_t             size;
  } bus_req_t;

  typedef struct packed {
    logic      ready;
    bus_word_u rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic              aw_valid;
    logic [ADDR_W-1:0] aw_addr;
    size_t             aw_size;
    logic              w_valid;
    logic [XLEN-1:0]   w_data;
    logic [STRB_W-1:0] w_strb;
    logic              b_ready;
    logic              ar_valid;
    logic [ADDR_W-1:0] ar_addr;
    size_t             ar_size;
    logic              r_ready;
  } axi_req_t;

  typedef struct packed {
    logic            aw_ready;
    logic            w_ready;
    logic            b_valid;
    logic            ar_ready;
    logic            r_valid;
    logic [XLEN-1:0] r_data;
  } axi_rsp_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WADDR,
    ST_WRESP,
    ST_RADDR,
    ST_RDATA
  } axi_state_e;

  // byte lanes touched by an access of the given size
  function automatic logic [STRB_W-1:0] byte_strb(size_t size, logic [2:0] off);
    logic [STRB_W-1:0] base;
    case (size)
      3'd0:    base = 8'h01;
      3'd1:    base = 8'h03;
      3'd2:    base = 8'h0f;
      default: base = 8'hff;
    endcase
    return base << off;
  endfunction

endpackage

`default_nettype wire
